// ==== files.f ====
+incdir+hw
+incdir+dv
hw/rvPkg.sv
hw/instPort.sv
hw/FetchSeq.sv
hw/InstQueue.sv
hw/Control.sv
hw/DecodeStage.sv
hw/FrontEnd.sv
dv/FrontEndTb.sv

// ==== dv/frontEndTasks.svh ====
function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// random fields; funct3 and funct7 kept random when negative
function automatic logic [31:0] makeWord(input logic [6:0] op, input int f3, input int f7);
    logic [31:0] w;
    seed = xorshift(seed);
    w    = seed;
    w[6:0] = op;
    if (f3 >= 0) w[14:12] = f3[2:0];
    if (f7 >= 0) w[31:25] = f7[6:0];
    return w;
endfunction

task automatic sendWord(input logic [31:0] w);
    instValid = 1'b1;
    inst      = w;
    @(negedge clk);
    instValid = 1'b0;
endtask

task automatic waitDec(output int waited);
    waited = 0;
    while (!decValid) begin
        if (waited == 20) begin
            $display("timed out waiting for decValid");
            abortRun();
        end
        @(negedge clk);
        waited++;
    end
endtask

task automatic checkOut(input logic [31:0] w, input logic [31:0] pc);
    checkVal("decPc", pc, decPc);
    checkVal("decCtrl", refCtrl(w), decCtrl);
    checkVal("imm", refImm(w), imm);
    checkVal("rd", w[11:7], rd);
    checkVal("rs1", w[19:15], rs1);
    checkVal("rs2", w[24:20], rs2);
endtask

task automatic decodeOne(input logic [6:0] op, input int f3, input int f7);
    logic [31:0] w;
    int          waited;
    w = makeWord(op, f3, f7);
    sendWord(w);
    waitDec(waited);
    checkVal("decValid latency", 1, waited);   // one cycle past the strobe edge
    checkOut(w, expPc);
    expPc = expPc + 4;
endtask

task automatic classSweep();
    for (int i = 0; i < 8; i++) begin
        decodeOne(ArtLog, i, 7'h00);
        decodeOne(ArtLog, i, 7'h01);    // M ops
        decodeOne(ArtImm, i, 7'h00);
        decodeOne(Load, i, -1);
        decodeOne(Store, i, -1);
        decodeOne(Branch, i, -1);
    end
    decodeOne(ArtLog, 0, 7'h20);
    decodeOne(ArtLog, 5, 7'h20);
    decodeOne(ArtImm, 5, 7'h20);
    decodeOne(Jal, -1, -1);
    decodeOne(Jalr, 0, -1);
    decodeOne(Lui, -1, -1);
    decodeOne(Auipc, -1, -1);
    decodeOne(Ecall, 0, -1);
endtask

task automatic unknownOp();
    decodeOne(7'b1111111, -1, -1);
    checkVal("decCtrl", 0, decCtrl);
    decodeOne(7'b0001111, -1, -1);  // fence is not handled
    checkVal("decCtrl", 0, decCtrl);
endtask

task automatic holdAndOverflow();
    logic [31:0] words [4];
    int          waited;
    hold = 1'b1;
    for (int i = 0; i < 4; i++) begin
        words[i] = makeWord(ArtImm, -1, -1);
        sendWord(words[i]);
        checkVal("queueFull", i == 3, queueFull);
        checkVal("decValid", 0, decValid);
        checkVal("overflow", 0, overflow);
    end
    sendWord(makeWord(Load, -1, -1));   // meets a full queue
    checkVal("overflow", 1, overflow);
    hold = 1'b0;
    waitDec(waited);
    checkVal("decValid latency", 1, waited);
    for (int i = 0; i < 4; i++) begin
        checkVal("decValid", 1, decValid);
        checkOut(words[i], expPc);
        expPc = expPc + 4;
        @(negedge clk);
    end
    repeat (3) begin
        checkVal("decValid", 0, decValid);
        @(negedge clk);
    end
    checkVal("overflow", 1, overflow);
    decodeOne(Lui, -1, -1);
endtask

task automatic redirectFlush();
    hold = 1'b1;
    for (int i = 0; i < 4; i++) begin
        sendWord(makeWord(ArtLog, -1, 7'h00));
    end
    checkVal("queueFull", 1, queueFull);
    redirect   = 1'b1;
    redirectPc = 32'h0000_8000;
    hold       = 1'b0;                   // decode would take the head at this edge
    sendWord(makeWord(Branch, -1, -1));  // same edge as redirect
    redirect = 1'b0;
    checkVal("overflow", 0, overflow);
    repeat (4) begin
        checkVal("decValid", 0, decValid);
        @(negedge clk);
    end
    checkVal("queueFull", 0, queueFull);
    expPc = 32'h0000_8000;
    decodeOne(Jal, -1, -1);
    decodeOne(Auipc, -1, -1);
endtask

task automatic resetClears();
    hold = 1'b1;
    for (int i = 0; i < 4; i++) begin
        sendWord(makeWord(Store, -1, -1));
    end
    checkVal("queueFull", 1, queueFull);
    checkVal("overflow", 1, overflow);
    rst  = 1'b1;
    hold = 1'b0;
    repeat (2) @(negedge clk);
    rst = 1'b0;
    checkVal("overflow", 0, overflow);
    checkVal("queueFull", 0, queueFull);
    checkVal("decValid", 0, decValid);
    expPc = `RESET_PC;
    decodeOne(Ecall, 0, -1);
endtask

// ==== dv/FrontEndTb.sv ====
`timescale 1ns/1ps
`include "core_defines.svh"

module FrontEndTb;
    import rvPkg::*;

    // lookup by funct3
    localparam aluOpE BaseOps [8] = '{Add, Sll, Slt, Sltu, Xor, Srl, Or, And};
    localparam aluOpE MulOps [8] = '{Mul, Mulh, Mulhsu, Mulhu, Div, Div, Rem, Rem};
    localparam ldstE LoadKinds [8] = '{Lb, Lh, Lw, None, Lbu, Lhu, None, None};
    localparam ldstE StoreKinds [8] = '{Sb, Sh, Sw, None, None, None, None, None};
    localparam bruOpE BranchOps [8] = '{Eq, Ne, Nop, Nop, Lt, Ge, Ltu, Geu};

    logic             clk;
    logic             rst;
    logic             instValid;
    logic [`XLEN-1:0] inst;
    logic             redirect;
    logic [`XLEN-1:0] redirectPc;
    logic             hold;
    logic             decValid;
    logic [`XLEN-1:0] decPc;
    ctrlS             decCtrl;
    logic [4:0]       rd;
    logic [4:0]       rs1;
    logic [4:0]       rs2;
    logic [`XLEN-1:0] imm;
    logic             queueFull;
    logic             overflow;

    logic [31:0]      seed;
    logic [31:0]      expPc;    // pc of the next word expected at the output

    FrontEnd DUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // expected control bundle, straight from the ISA rules
    function automatic ctrlS refCtrl(input logic [31:0] w);
        ctrlS       c;
        logic [2:0] f3;
        c  = '0;
        f3 = w[14:12];
        case (w[6:0])
            ArtLog: begin
                c.regWrite = 1'b1;
                if (w[31:25] == 7'h01) c.aluOp = MulOps[f3];
                else if (w[30] && f3 == 3'd0) c.aluOp = Sub;
                else if (w[30] && f3 == 3'd5) c.aluOp = Sra;
                else c.aluOp = BaseOps[f3];
            end
            ArtImm: begin
                c.aluSrc   = Imm;
                c.regWrite = 1'b1;
                c.aluOp    = (w[30] && f3 == 3'd5) ? Sra : BaseOps[f3];
            end
            Load: begin
                c.aluSrc   = Imm;
                c.memRead  = 1'b1;
                c.regWrite = 1'b1;
                c.memToReg = 1'b1;
                c.ldst     = LoadKinds[f3];
            end
            Store: begin
                c.aluSrc   = Imm;
                c.memWrite = 1'b1;
                c.ldst     = StoreKinds[f3];
            end
            Branch: begin
                c.branch  = 1'b1;
                c.predict = 1'b1;
                c.bruOp   = BranchOps[f3];
            end
            Jal, Jalr: begin
                c.bruOp    = Jmp;
                c.aluSrc   = Pc4;
                c.regWrite = 1'b1;
                c.branch   = 1'b1;
                c.ujtype   = (w[6:0] == Jal);
            end
            Lui, Auipc: begin
                c.aluSrc   = (w[6:0] == Lui) ? Imm : PcImm;
                c.regWrite = 1'b1;
                c.ujtype   = 1'b1;
            end
            Ecall: c.excp = 1'b1;
            default: c = '0;
        endcase
        return c;
    endfunction

    function automatic logic [31:0] refImm(input logic [31:0] w);
        case (w[6:0])
            Load, ArtImm, Jalr, Ecall: return {{20{w[31]}}, w[31:20]};
            Store:      return {{20{w[31]}}, w[31:25], w[11:7]};
            Branch:     return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            Lui, Auipc: return {w[31:12], 12'h000};
            Jal:        return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            default:    return '0;
        endcase
    endfunction

    task automatic abortRun();
        $display(">>> FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkVal(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("ERROR time=%0t %s expected=%h actual=%h", $time, name, exp, act);
            abortRun();
        end
    endtask

    `include "frontEndTasks.svh"

    initial begin
        rst        = 1'b1;
        instValid  = 1'b0;
        inst       = '0;
        redirect   = 1'b0;
        redirectPc = '0;
        hold       = 1'b0;
        seed       = 32'h4dd7_c0d4;
        expPc      = `RESET_PC;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        classSweep();
        unknownOp();
        redirectFlush();
        holdAndOverflow();
        resetClears();
        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== hw/FrontEnd.sv ====
`timescale 1ns/1ps
`include "core_defines.svh"

module FrontEnd (
    input  logic             clk,
    input  logic             rst,
    input  logic             instValid,
    input  logic [`XLEN-1:0] inst,
    input  logic             redirect,
    input  logic [`XLEN-1:0] redirectPc,
    input  logic             hold,
    output logic             decValid,
    output logic [`XLEN-1:0] decPc,
    output rvPkg::ctrlS      decCtrl,
    output logic [4:0]       rd,
    output logic [4:0]       rs1,
    output logic [4:0]       rs2,
    output logic [`XLEN-1:0] imm,
    output logic             queueFull,
    output logic             overflow
);

    instPort fetchLink ();  // fetch -> queue
    instPort decLink ();    // queue -> decode

    FetchSeq uFetch (
        .clk        (clk),
        .rst        (rst),
        .instValid  (instValid),
        .inst       (inst),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .overflow   (overflow),
        .out        (fetchLink)
    );

    InstQueue uQueue (
        .clk   (clk),
        .rst   (rst),
        .flush (redirect),
        .full  (queueFull),
        .in    (fetchLink),
        .out   (decLink)
    );

    DecodeStage uDecode (
        .clk      (clk),
        .rst      (rst),
        .flush    (redirect),
        .hold     (hold),
        .in       (decLink),
        .decValid (decValid),
        .decPc    (decPc),
        .decCtrl  (decCtrl),
        .rd       (rd),
        .rs1      (rs1),
        .rs2      (rs2),
        .imm      (imm)
    );

endmodule

// ==== hw/DecodeStage.sv ====
`timescale 1ns/1ps
`include "core_defines.svh"

module DecodeStage (
    input  logic             clk,
    input  logic             rst,
    input  logic             flush,
    input  logic             hold,
    instPort.consumer        in,
    output logic             decValid,
    output logic [`XLEN-1:0] decPc,
    output rvPkg::ctrlS      decCtrl,
    output logic [4:0]       rd,
    output logic [4:0]       rs1,
    output logic [4:0]       rs2,
    output logic [`XLEN-1:0] imm
);
    import rvPkg::*;

    logic [`XLEN-1:0] word;
    opcodeE           opcode;
    ctrlS             ctrl;
    logic [`XLEN-1:0] immNext;
    logic             accept;

    assign word     = in.inst;
    assign opcode   = opcodeE'(word[6:0]);
    assign in.ready = !hold;
    assign accept   = in.valid && in.ready;

    Control uControl (
        .inst (word),
        .ctrl (ctrl)
    );

    // immediate by format
    always_comb begin
        case (opcode)
            Load, ArtImm, Jalr, Ecall: begin
                immNext = {{(`XLEN-12){word[31]}}, word[31:20]};
            end
            Store: begin
                immNext = {{(`XLEN-12){word[31]}}, word[31:25], word[11:7]};
            end
            Branch: begin
                immNext = {{(`XLEN-12){word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
            end
            Lui, Auipc: begin
                immNext = {word[31:12], 12'b0};
            end
            Jal: begin
                immNext = {{(`XLEN-20){word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
            end
            default: begin
                immNext = '0;   // r-type has none
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            decValid <= 1'b0;
        end else begin
            decValid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            decPc   <= in.pc;
            decCtrl <= ctrl;
            rd      <= word[11:7];
            rs1     <= word[19:15];
            rs2     <= word[24:20];
            imm     <= immNext;
        end
    end

endmodule

// ==== hw/Control.sv ====
`timescale 1ns/1ps
`include "core_defines.svh"

module Control (
    input  logic [`XLEN-1:0] inst,
    output rvPkg::ctrlS      ctrl
);
    import rvPkg::*;

    opcodeE     opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = opcodeE'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        ctrl = '0;  // unknown opcode stays all zero
        case (opcode)
            ArtLog: begin
                ctrl.aluSrc   = Reg;
                ctrl.regWrite = 1'b1;
                if (funct7 == 7'h01) begin
                    // M extension
                    case (funct3)
                        3'b000:  ctrl.aluOp = Mul;
                        3'b001:  ctrl.aluOp = Mulh;
                        3'b010:  ctrl.aluOp = Mulhsu;
                        3'b011:  ctrl.aluOp = Mulhu;
                        3'b100:  ctrl.aluOp = Div;
                        3'b101:  ctrl.aluOp = Div;
                        default: ctrl.aluOp = Rem;
                    endcase
                end else begin
                    case (funct3)
                        3'b000: begin
                            if (funct7[5]) ctrl.aluOp = Sub;
                            else           ctrl.aluOp = Add;
                        end
                        3'b001:  ctrl.aluOp = Sll;
                        3'b010:  ctrl.aluOp = Slt;
                        3'b011:  ctrl.aluOp = Sltu;
                        3'b100:  ctrl.aluOp = Xor;
                        3'b101: begin
                            if (funct7[5]) ctrl.aluOp = Sra;
                            else           ctrl.aluOp = Srl;
                        end
                        3'b110:  ctrl.aluOp = Or;
                        default: ctrl.aluOp = And;
                    endcase
                end
            end
            ArtImm: begin
                ctrl.aluSrc   = Imm;
                ctrl.regWrite = 1'b1;
                case (funct3)
                    3'b000:  ctrl.aluOp = Add;
                    3'b001:  ctrl.aluOp = Sll;
                    3'b010:  ctrl.aluOp = Slt;
                    3'b011:  ctrl.aluOp = Sltu;
                    3'b100:  ctrl.aluOp = Xor;
                    3'b101: begin
                        if (funct7[5]) ctrl.aluOp = Sra;
                        else           ctrl.aluOp = Srl;
                    end
                    3'b110:  ctrl.aluOp = Or;
                    default: ctrl.aluOp = And;
                endcase
            end
            Load: begin
                ctrl.aluOp    = Add;    // base + offset
                ctrl.aluSrc   = Imm;
                ctrl.memRead  = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.memToReg = 1'b1;
                case (funct3)
                    3'b000:  ctrl.ldst = Lb;
                    3'b001:  ctrl.ldst = Lh;
                    3'b010:  ctrl.ldst = Lw;
                    3'b100:  ctrl.ldst = Lbu;
                    3'b101:  ctrl.ldst = Lhu;
                    default: ctrl.ldst = None;
                endcase
            end
            Store: begin
                ctrl.aluOp    = Add;
                ctrl.aluSrc   = Imm;
                ctrl.memWrite = 1'b1;
                case (funct3)
                    3'b000:  ctrl.ldst = Sb;
                    3'b001:  ctrl.ldst = Sh;
                    3'b010:  ctrl.ldst = Sw;
                    default: ctrl.ldst = None;
                endcase
            end
            Branch: begin
                ctrl.aluOp   = Add;
                ctrl.aluSrc  = Reg;
                ctrl.branch  = 1'b1;
                ctrl.predict = 1'b1;
                case (funct3)
                    3'b000:  ctrl.bruOp = Eq;
                    3'b001:  ctrl.bruOp = Ne;
                    3'b100:  ctrl.bruOp = Lt;
                    3'b101:  ctrl.bruOp = Ge;
                    3'b110:  ctrl.bruOp = Ltu;
                    3'b111:  ctrl.bruOp = Geu;
                    default: ctrl.bruOp = Nop;
                endcase
            end
            Jalr, Jal: begin
                ctrl.aluOp    = Add;
                ctrl.bruOp    = Jmp;
                ctrl.aluSrc   = Pc4;
                ctrl.regWrite = 1'b1;
                ctrl.branch   = 1'b1;
                ctrl.ujtype   = (opcode == Jal);
            end
            Lui: begin
                ctrl.aluOp    = Add;
                ctrl.aluSrc   = Imm;
                ctrl.regWrite = 1'b1;
                ctrl.ujtype   = 1'b1;
            end
            Auipc: begin
                ctrl.aluOp    = Add;
                ctrl.aluSrc   = PcImm;
                ctrl.regWrite = 1'b1;
                ctrl.ujtype   = 1'b1;
            end
            Ecall: begin
                ctrl.excp = 1'b1;
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

endmodule

// ==== hw/InstQueue.sv ====
`timescale 1ns/1ps
`include "core_defines.svh"

module InstQueue (
    input  logic      clk,
    input  logic      rst,
    input  logic      flush,
    output logic      full,
    instPort.consumer in,
    instPort.producer out
);

    localparam int PtrW = $clog2(`QUEUE_DEPTH);

    logic [`XLEN-1:0] instMem [`QUEUE_DEPTH];
    logic [`XLEN-1:0] pcMem   [`QUEUE_DEPTH];

    logic [PtrW-1:0] wrPtr;
    logic [PtrW-1:0] rdPtr;
    logic [PtrW:0]   count;
    logic            push;
    logic            pop;

    assign full     = (count == `QUEUE_DEPTH);
    assign in.ready = !full;
    assign push     = in.valid && in.ready;

    assign out.valid = (count != 0);
    assign out.inst  = instMem[rdPtr];
    assign out.pc    = pcMem[rdPtr];
    assign pop       = out.valid && out.ready;

    always_ff @(posedge clk) begin
        if (push) begin
            instMem[wrPtr] <= in.inst;
            pcMem[wrPtr]   <= in.pc;
        end
    end

    // pointers wrap on their own since depth is a power of two
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // idle or push+pop
            endcase
        end
    end

endmodule

// ==== hw/FetchSeq.sv ====
`timescale 1ns/1ps
`include "core_defines.svh"

module FetchSeq (
    input  logic             clk,
    input  logic             rst,
    input  logic             instValid,
    input  logic [`XLEN-1:0] inst,
    input  logic             redirect,
    input  logic [`XLEN-1:0] redirectPc,
    output logic             overflow,
    instPort.producer        out
);

    logic [`XLEN-1:0] pc;
    logic             accepted;

    // a strobe on a redirect edge is dropped silently
    assign out.inst  = inst;
    assign out.pc    = pc;
    assign out.valid = instValid && !redirect;

    assign accepted = out.valid && out.ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `RESET_PC;
        end else if (redirect) begin
            pc <= redirectPc;
        end else if (accepted) begin
            pc <= pc + `XLEN'd4;
        end
    end

    // sticky until reset
    always_ff @(posedge clk) begin
        if (rst) begin
            overflow <= 1'b0;
        end else if (out.valid && !out.ready) begin
            overflow <= 1'b1;
        end
    end

endmodule

// ==== hw/instPort.sv ====
`timescale 1ns/1ps
`include "core_defines.svh"

interface instPort;

    logic [`XLEN-1:0] inst;
    logic [`XLEN-1:0] pc;
    logic             valid;
    logic             ready;

    modport producer (
        output inst, pc, valid,
        input  ready
    );

    modport consumer (
        input  inst, pc, valid,
        output ready
    );

endinterface

// ==== hw/rvPkg.sv ====
package rvPkg;

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        ArtLog = 7'b0110011,
        ArtImm = 7'b0010011,
        Load   = 7'b0000011,
        Store  = 7'b0100011,
        Branch = 7'b1100011,
        Jalr   = 7'b1100111,
        Jal    = 7'b1101111,
        Lui    = 7'b0110111,
        Auipc  = 7'b0010111,
        Ecall  = 7'b1110011
    } opcodeE;

    typedef enum logic [4:0] {
        Add, Sub, Sll, Slt,
        Sltu, Xor, Srl, Sra,
        Or, And, Mul, Mulh,
        Mulhsu, Mulhu, Div, Rem
    } aluOpE;

    typedef enum logic [2:0] {
        Nop, Eq, Ne, Lt,
        Ge, Ltu, Geu, Jmp
    } bruOpE;

    typedef enum logic [1:0] {
        Reg,
        Imm,
        Pc4,    // link address for jumps
        PcImm   // auipc
    } aluSrcE;

    typedef enum logic [3:0] {
        None,
        Lb, Lh, Lw, Lbu, Lhu,
        Sb, Sh, Sw
    } ldstE;

    typedef struct packed {
        bruOpE  bruOp;      // ex
        aluOpE  aluOp;
        aluSrcE aluSrc;
        ldstE   ldst;       // mem
        logic   memWrite;
        logic   memRead;
        logic   regWrite;   // wb
        logic   memToReg;
        logic   branch;
        logic   predict;
        logic   ujtype;
        logic   excp;
    } ctrlS;

endpackage

// ==== hw/core_defines.svh ====
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// width of instruction word, pc and immediate
`define XLEN 32

// pc tagged onto the first word after reset
`define RESET_PC 32'h0000_1000

// instruction queue entries, power of two
`define QUEUE_DEPTH 4

`endif
